//--- Makefile
# Verilator build for the camera capture testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_camera_capture
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= ALL TESTS PASSED

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail
run: compile
	./$(SIM_BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/tb_camera_capture.sv
module tb_camera_capture;
  import cam_pkg::*;

  localparam int tb_width     = 16;
  localparam int tb_height    = 4;
  localparam int frame_pixels = tb_width * tb_height;
  localparam int wait_limit   = 4000;

  logic         clk_camera;
  logic         recent_reset;
  logic         cam_pclk;
  logic         cam_hsync;
  logic         cam_vsync;
  byte_t        cam_data;
  logic         psel;
  logic         penable;
  logic         pwrite;
  logic [7:0]   paddr;
  logic [31:0]  pwdata;
  logic [31:0]  prdata;
  logic         pready;
  logic         pslverr;
  logic         chunk_valid;
  chunk_t       chunk;
  logic         chunk_last;
  logic         chunk_ready;

  // ============================================================
  // model state
  // ============================================================

  integer       seed;
  integer       ready_seed;
  // 0 always ready, 1 random ready, 2 stalled
  int           ready_mode;
  logic         checking;
  int           frames_expected;
  logic         m_enable;
  channel_sel_e m_chan;
  chan_t        m_lower;
  chan_t        m_upper;
  pixel_t       m_color;
  pixel_t       frame_pix [frame_pixels];
  chunk_t       exp_chunks [$];
  logic         exp_lasts [$];
  chunk_t       exp_c;
  logic         exp_l;

  camera_capture_top #(
    .frame_width  (tb_width),
    .frame_height (tb_height)
  ) i_dut (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .cam_pclk_i    (cam_pclk),
    .cam_hsync_i   (cam_hsync),
    .cam_vsync_i   (cam_vsync),
    .cam_data_i    (cam_data),
    .psel_i        (psel),
    .penable_i     (penable),
    .pwrite_i      (pwrite),
    .paddr_i       (paddr),
    .pwdata_i      (pwdata),
    .prdata_o      (prdata),
    .pready_o      (pready),
    .pslverr_o     (pslverr),
    .chunk_valid_o (chunk_valid),
    .chunk_o       (chunk),
    .chunk_last_o  (chunk_last),
    .chunk_ready_i (chunk_ready)
  );

  initial begin
    clk_camera = 1'b0;
    forever #2 clk_camera = ~clk_camera;
  end

  // downstream writer, changes one unit after each rising edge
  initial begin
    chunk_ready = 1'b0;
    forever begin
      @(posedge clk_camera);
      #1;
      case (ready_mode)
        0: chunk_ready = 1'b1;
        // roughly three quarters duty
        1: chunk_ready = (($random(ready_seed) % 4) != 0);
        default: chunk_ready = 1'b0;
      endcase
    end
  end

  // ============================================================
  // error handling and compare tasks
  // ============================================================

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_chunk(input chunk_t got, input logic got_last,
                             input chunk_t exp, input logic exp_last);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED t=%0t chunk_o got %h expected %h",
                         $time, got, exp));
    end
    if (got_last !== exp_last) begin
      fail_run($sformatf("CHECK FAILED t=%0t chunk_last_o got %b expected %b",
                         $time, got_last, exp_last));
    end
  endtask

  task automatic check_reg(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED t=%0t %s got %h expected %h",
                         $time, name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED t=%0t %s got %b expected %b",
                         $time, name, got, exp));
    end
  endtask

  // accepted chunks are compared in order against the model queue
  always @(negedge clk_camera) begin
    if (checking && chunk_valid && chunk_ready) begin
      if (exp_chunks.size() == 0) begin
        fail_run("a chunk came out that the model did not expect");
      end else begin
        exp_c = exp_chunks.pop_front();
        exp_l = exp_lasts.pop_front();
        check_chunk(chunk, chunk_last, exp_c, exp_l);
      end
    end
  end

  // ============================================================
  // apb master
  // ============================================================

  task automatic step(input int n);
    repeat (n) @(posedge clk_camera);
    #1;
  endtask

  task automatic apb_access(input logic write, input logic [7:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int waited;
    step(1);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    step(1);
    penable = 1'b1;
    // sample the access phase away from the clock edge
    @(negedge clk_camera);
    waited = 0;
    while (!pready) begin
      if (waited >= wait_limit) begin
        fail_run("timeout: apb access phase never saw pready");
      end
      waited++;
      @(negedge clk_camera);
    end
    rdata = prdata;
    err   = pslverr;
    step(1);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write_ok(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    apb_access(1'b1, addr, data, rd, err);
    check_flag("pslverr_o", err, 1'b0);
  endtask

  task automatic read_expect(input logic [7:0] addr, input logic [31:0] exp,
                             input string name);
    logic [31:0] rd;
    logic        err;
    apb_access(1'b0, addr, 32'd0, rd, err);
    check_flag("pslverr_o", err, 1'b0);
    check_reg(name, rd, exp);
  endtask

  // program the keyer and mirror it in the model
  task automatic set_key(input logic en, input channel_sel_e sel, input chan_t lo,
                         input chan_t hi, input pixel_t color);
    apb_write_ok(8'h00, {29'd0, sel, en});
    apb_write_ok(8'h04, {24'd0, lo});
    apb_write_ok(8'h08, {24'd0, hi});
    apb_write_ok(8'h0c, {16'd0, color});
    m_enable = en;
    m_chan   = sel;
    m_lower  = lo;
    m_upper  = hi;
    m_color  = color;
  endtask

  // ============================================================
  // reference model
  // ============================================================

  function automatic chan_t channel_value(input pixel_t p, input channel_sel_e sel);
    case (sel)
      chan_red:  return {p[15:11], 3'b000};
      chan_blue: return {p[4:0], 3'b000};
      // unnamed code keys on green
      default:   return {p[10:5], 2'b00};
    endcase
  endfunction

  function automatic pixel_t key_model(input pixel_t p);
    chan_t v;
    v = channel_value(p, m_chan);
    if (m_enable && (v >= m_lower) && (v <= m_upper)) begin
      return m_color;
    end
    return p;
  endfunction

  task automatic make_frame();
    for (int i = 0; i < frame_pixels; i++) begin
      frame_pix[i] = pixel_t'($random(seed));
    end
  endtask

  // first pixel of each group of eight in the low 16 bits
  task automatic model_frame();
    logic [127:0] flat;
    flat = '0;
    for (int i = 0; i < frame_pixels; i++) begin
      flat[16*(i%8) +: 16] = key_model(frame_pix[i]);
      if (i % 8 == 7) begin
        exp_chunks.push_back(chunk_t'(flat));
        exp_lasts.push_back(i == frame_pixels - 1);
      end
    end
  endtask

  // bounds taken from real pixels so the window edges get hit
  task automatic choose_window();
    channel_sel_e sel;
    chan_t        a;
    chan_t        b;
    sel = channel_sel_e'(2'($random(seed)));
    a   = channel_value(frame_pix[$unsigned($random(seed)) % frame_pixels], sel);
    b   = channel_value(frame_pix[$unsigned($random(seed)) % frame_pixels], sel);
    if (a <= b) begin
      set_key(1'b1, sel, a, b, pixel_t'($random(seed)));
    end else begin
      set_key(1'b1, sel, b, a, pixel_t'($random(seed)));
    end
  endtask

  // ============================================================
  // camera bus driver
  // ============================================================

  // pclk period of 8 clk_camera cycles, data set while pclk is low
  task automatic drive_byte(input byte_t b);
    step(1);
    cam_data = b;
    cam_pclk = 1'b0;
    step(4);
    cam_pclk = 1'b1;
    step(3);
  endtask

  task automatic send_frame();
    step(1);
    cam_vsync = 1'b1;
    step(8);
    cam_vsync = 1'b0;
    step(8);
    for (int row = 0; row < tb_height; row++) begin
      cam_hsync = 1'b1;
      step(4);
      for (int col = 0; col < tb_width; col++) begin
        drive_byte(frame_pix[row*tb_width + col][15:8]);
        drive_byte(frame_pix[row*tb_width + col][7:0]);
      end
      step(1);
      cam_pclk  = 1'b0;
      cam_hsync = 1'b0;
      step(12);
    end
    step(16);
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    @(negedge clk_camera);
    while ((exp_chunks.size() != 0) || chunk_valid) begin
      if (waited >= wait_limit) begin
        fail_run("timeout: the chunk stream did not drain");
      end
      waited++;
      @(negedge clk_camera);
    end
    step(1);
  endtask

  task automatic run_frame();
    model_frame();
    send_frame();
    wait_drain();
    frames_expected++;
  endtask

  // ============================================================
  // test sequence
  // ============================================================

  initial begin
    logic [31:0] rd;
    logic        err;
    seed            = 32'h4c2b58ea;
    ready_seed      = ~seed;
    ready_mode      = 0;
    checking        = 1'b1;
    frames_expected = 0;
    recent_reset    = 1'b1;
    cam_pclk        = 1'b0;
    cam_hsync       = 1'b0;
    cam_vsync       = 1'b0;
    cam_data        = 8'h00;
    psel            = 1'b0;
    penable         = 1'b0;
    pwrite          = 1'b0;
    paddr           = 8'h00;
    pwdata          = 32'd0;
    // reset key setup, green window 0x00..0x40
    m_enable        = 1'b1;
    m_chan          = chan_green;
    m_lower         = 8'h00;
    m_upper         = 8'h40;
    m_color         = 16'h2277;
    repeat (16) @(posedge clk_camera);
    #1;
    recent_reset = 1'b0;
    step(4);

    // register values out of reset
    read_expect(8'h00, 32'h0000_0001, "ctrl");
    read_expect(8'h04, 32'h0000_0000, "lower");
    read_expect(8'h08, 32'h0000_0040, "upper");
    read_expect(8'h0c, 32'h0000_2277, "key_color");
    read_expect(8'h10, 32'h0000_0000, "status");

    // keying off, pixels pass untouched
    set_key(1'b0, chan_green, 8'h00, 8'h40, 16'h2277);
    repeat (2) begin
      make_frame();
      run_frame();
    end

    // random windows under random back-pressure
    ready_mode = 1;
    repeat (4) begin
      make_frame();
      choose_window();
      run_frame();
    end

    // writer stalled for a whole frame, chunks get dropped
    ready_mode = 2;
    checking   = 1'b0;
    make_frame();
    send_frame();
    read_expect(8'h10, {16'(frames_expected), 15'd0, 1'b1}, "status");
    ready_mode = 0;
    wait_drain();
    checking = 1'b1;
    apb_write_ok(8'h10, 32'h0000_0001);
    read_expect(8'h10, {16'(frames_expected), 15'd0, 1'b0}, "status");

    // capture recovers after the drop
    make_frame();
    run_frame();
    step(4);
    read_expect(8'h10, {16'(frames_expected), 15'd0, 1'b0}, "status");

    // unmapped address errors out and touches nothing
    apb_access(1'b1, 8'h20, 32'hffff_ffff, rd, err);
    check_flag("pslverr_o", err, 1'b1);
    apb_access(1'b0, 8'h20, 32'd0, rd, err);
    check_flag("pslverr_o", err, 1'b1);
    read_expect(8'h00, {29'd0, m_chan, m_enable}, "ctrl");
    read_expect(8'h04, {24'd0, m_lower}, "lower");
    read_expect(8'h08, {24'd0, m_upper}, "upper");
    read_expect(8'h0c, {16'd0, m_color}, "key_color");
    read_expect(8'h10, {16'(frames_expected), 15'd0, 1'b0}, "status");

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- rtl/cam_pkg.sv
package cam_pkg;

  // ============================================================
  // data types on the capture path
  // ============================================================

  // one camera bus byte
  typedef logic [7:0] byte_t;

  // rgb565, red in [15:11], green in [10:5], blue in [4:0]
  typedef logic [15:0] pixel_t;

  // one colour channel widened to 8 bits
  typedef logic [7:0] chan_t;

  localparam int pixels_per_chunk = 8;

  // element 0 is the first pixel and lands in bits [15:0]
  typedef pixel_t [pixels_per_chunk-1:0] chunk_t;

  // ============================================================
  // configuration encodings
  // ============================================================

  // code 2'b11 has no name; the keyer falls back to green for it
  typedef enum logic [1:0] {
    chan_green = 2'd0,
    chan_red   = 2'd1,
    chan_blue  = 2'd2
  } channel_sel_e;

  // apb word addresses
  typedef enum logic [7:0] {
    reg_ctrl      = 8'h00,
    reg_lower     = 8'h04,
    reg_upper     = 8'h08,
    reg_key_color = 8'h0c,
    reg_status    = 8'h10
  } reg_addr_e;

  // power-up key setup, a green screen window
  localparam logic         reset_enable    = 1'b1;
  localparam channel_sel_e reset_channel   = chan_green;
  localparam chan_t        reset_lower     = 8'h00;
  localparam chan_t        reset_upper     = 8'h40;
  localparam pixel_t       reset_key_color = 16'h2277;

endpackage

//--- rtl/camera_capture_top.sv
module camera_capture_top #(
  parameter int frame_width  = 1280,
  parameter int frame_height = 720
) (
  input  logic             clk_camera,
  input  logic             recent_reset,
  // parallel camera bus
  input  logic             cam_pclk_i,
  input  logic             cam_hsync_i,
  input  logic             cam_vsync_i,
  input  cam_pkg::byte_t   cam_data_i,
  // apb slave
  input  logic             psel_i,
  input  logic             penable_i,
  input  logic             pwrite_i,
  input  logic [7:0]       paddr_i,
  input  logic [31:0]      pwdata_i,
  output logic [31:0]      prdata_o,
  output logic             pready_o,
  output logic             pslverr_o,
  // chunk stream to the memory writer
  output logic             chunk_valid_o,
  output cam_pkg::chunk_t  chunk_o,
  output logic             chunk_last_o,
  input  logic             chunk_ready_i
);
  import cam_pkg::*;

  // ============================================================
  // internal wires
  // ============================================================

  logic         raw_valid;
  pixel_t       raw_pixel;
  logic         raw_last;
  logic         key_valid;
  pixel_t       key_pixel;
  logic         key_last;
  logic         key_enable;
  channel_sel_e key_channel;
  chan_t        key_lower;
  chan_t        key_upper;
  pixel_t       key_color;
  logic         overflow;
  logic         frame_done;

  // camera bytes to rgb565 pixels
  pixel_reconstruct #(
    .frame_width  (frame_width),
    .frame_height (frame_height)
  ) i_pixel_reconstruct (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .cam_pclk_i    (cam_pclk_i),
    .cam_hsync_i   (cam_hsync_i),
    .cam_vsync_i   (cam_vsync_i),
    .cam_data_i    (cam_data_i),
    .pixel_valid_o (raw_valid),
    .pixel_o       (raw_pixel),
    .pixel_last_o  (raw_last)
  );

  chroma_key i_chroma_key (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .pixel_valid_i (raw_valid),
    .pixel_i       (raw_pixel),
    .pixel_last_i  (raw_last),
    .key_enable_i  (key_enable),
    .channel_i     (key_channel),
    .lower_i       (key_lower),
    .upper_i       (key_upper),
    .key_color_i   (key_color),
    .pixel_valid_o (key_valid),
    .pixel_o       (key_pixel),
    .pixel_last_o  (key_last)
  );

  // eight pixels per 128-bit chunk
  chunk_stacker i_chunk_stacker (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .pixel_valid_i (key_valid),
    .pixel_i       (key_pixel),
    .pixel_last_i  (key_last),
    .chunk_valid_o (chunk_valid_o),
    .chunk_o       (chunk_o),
    .chunk_last_o  (chunk_last_o),
    .chunk_ready_i (chunk_ready_i),
    .overflow_o    (overflow),
    .frame_done_o  (frame_done)
  );

  key_config_apb i_key_config_apb (
    .clk_camera   (clk_camera),
    .recent_reset (recent_reset),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .paddr_i      (paddr_i),
    .pwdata_i     (pwdata_i),
    .prdata_o     (prdata_o),
    .pready_o     (pready_o),
    .pslverr_o    (pslverr_o),
    .overflow_i   (overflow),
    .frame_done_i (frame_done),
    .key_enable_o (key_enable),
    .channel_o    (key_channel),
    .lower_o      (key_lower),
    .upper_o      (key_upper),
    .key_color_o  (key_color)
  );

endmodule

//--- rtl/chroma_key.sv
module chroma_key (
  input  logic                   clk_camera,
  input  logic                   recent_reset,
  input  logic                   pixel_valid_i,
  input  cam_pkg::pixel_t        pixel_i,
  input  logic                   pixel_last_i,
  input  logic                   key_enable_i,
  input  cam_pkg::channel_sel_e  channel_i,
  input  cam_pkg::chan_t         lower_i,
  input  cam_pkg::chan_t         upper_i,
  input  cam_pkg::pixel_t        key_color_i,
  output logic                   pixel_valid_o,
  output cam_pkg::pixel_t        pixel_o,
  output logic                   pixel_last_o
);
  import cam_pkg::*;

  chan_t chan_value;
  logic  in_window;
  logic  keyed;

  // ============================================================
  // channel extraction, zero padded to 8 bits
  // ============================================================

  always_comb begin
    case (channel_i)
      chan_red:  chan_value = {pixel_i[15:11], 3'b000};
      chan_blue: chan_value = {pixel_i[4:0], 3'b000};
      // green, and the unnamed code as well
      default:   chan_value = {pixel_i[10:5], 2'b00};
    endcase
  end

  // inclusive on both bounds
  assign in_window = (chan_value >= lower_i) && (chan_value <= upper_i);
  assign keyed     = key_enable_i & in_window;

  // ============================================================
  // output register
  // ============================================================

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      pixel_valid_o <= 1'b0;
      pixel_last_o  <= 1'b0;
    end else begin
      pixel_valid_o <= pixel_valid_i;
      pixel_last_o  <= pixel_valid_i & pixel_last_i;
    end
  end

  always_ff @(posedge clk_camera) begin
    if (pixel_valid_i) begin
      // swap in the key colour when the channel falls in the window
      pixel_o <= keyed ? key_color_i : pixel_i;
    end
  end

endmodule

//--- rtl/chunk_stacker.sv
module chunk_stacker (
  input  logic             clk_camera,
  input  logic             recent_reset,
  input  logic             pixel_valid_i,
  input  cam_pkg::pixel_t  pixel_i,
  input  logic             pixel_last_i,
  output logic             chunk_valid_o,
  output cam_pkg::chunk_t  chunk_o,
  output logic             chunk_last_o,
  input  logic             chunk_ready_i,
  output logic             overflow_o,
  output logic             frame_done_o
);
  import cam_pkg::*;

  localparam int slot_w = $clog2(pixels_per_chunk);

  logic [slot_w-1:0] slot_q;
  chunk_t            asm_buf;
  logic              asm_last_q;
  logic              asm_full_q;
  logic              out_held;

  // output still owned by the downstream writer this cycle
  assign out_held = chunk_valid_o & ~chunk_ready_i;

  // ============================================================
  // assembly of eight pixels
  // ============================================================

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      slot_q     <= '0;
      asm_last_q <= 1'b0;
      asm_full_q <= 1'b0;
    end else begin
      // full is a one cycle flag, the hand-off happens right after it
      asm_full_q <= 1'b0;
      if (pixel_valid_i) begin
        slot_q <= slot_q + 1'b1;
        if (slot_q == '0) begin
          asm_last_q <= pixel_last_i;
        end else begin
          asm_last_q <= asm_last_q | pixel_last_i;
        end
        if (slot_q == slot_w'(pixels_per_chunk - 1)) begin
          asm_full_q <= 1'b1;
        end
      end
    end
  end

  // payload write, slot 0 is the low word
  always_ff @(posedge clk_camera) begin
    if (pixel_valid_i) begin
      asm_buf[slot_q] <= pixel_i;
    end
  end

  // ============================================================
  // output register and valid/ready handshake
  // ============================================================

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      chunk_valid_o <= 1'b0;
      chunk_last_o  <= 1'b0;
      overflow_o    <= 1'b0;
      frame_done_o  <= 1'b0;
    end else begin
      // a completed chunk with nowhere to go is lost, last flag included
      overflow_o   <= asm_full_q & out_held;
      // count frames only on a chunk the writer actually took
      frame_done_o <= chunk_valid_o & chunk_ready_i & chunk_last_o;
      if (asm_full_q && !out_held) begin
        chunk_valid_o <= 1'b1;
        chunk_last_o  <= asm_last_q;
      end else if (chunk_ready_i) begin
        chunk_valid_o <= 1'b0;
        chunk_last_o  <= 1'b0;
      end
    end
  end

  // the assembly buffer is read before the next chunk's first write lands
  always_ff @(posedge clk_camera) begin
    if (asm_full_q && !out_held) begin
      chunk_o <= asm_buf;
    end
  end

endmodule

//--- rtl/key_config_apb.sv
module key_config_apb (
  input  logic                   clk_camera,
  input  logic                   recent_reset,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  logic [7:0]             paddr_i,
  input  logic [31:0]            pwdata_i,
  output logic [31:0]            prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o,
  input  logic                   overflow_i,
  input  logic                   frame_done_i,
  output logic                   key_enable_o,
  output cam_pkg::channel_sel_e  channel_o,
  output cam_pkg::chan_t         lower_o,
  output cam_pkg::chan_t         upper_o,
  output cam_pkg::pixel_t        key_color_o
);
  import cam_pkg::*;

  reg_addr_e   addr;
  logic        access;
  logic        addr_hit;
  logic        wr_en;
  logic [31:0] rdata;
  logic        overflow_q;
  logic [15:0] frame_count_q;

  // no wait states, every access phase completes
  assign pready_o = 1'b1;
  assign access   = psel_i & penable_i;
  assign wr_en    = access & pwrite_i & addr_hit;
  assign addr     = reg_addr_e'(paddr_i);

  // ============================================================
  // address decode and read mux
  // ============================================================

  always_comb begin
    addr_hit = 1'b1;
    rdata    = '0;
    case (addr)
      reg_ctrl:      rdata = {29'd0, channel_o, key_enable_o};
      reg_lower:     rdata = {24'd0, lower_o};
      reg_upper:     rdata = {24'd0, upper_o};
      reg_key_color: rdata = {16'd0, key_color_o};
      reg_status:    rdata = {frame_count_q, 15'd0, overflow_q};
      default:       addr_hit = 1'b0;
    endcase
  end

  assign prdata_o  = access ? rdata : '0;
  assign pslverr_o = access & ~addr_hit;

  // ============================================================
  // key registers
  // ============================================================

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      key_enable_o <= reset_enable;
      channel_o    <= reset_channel;
      lower_o      <= reset_lower;
      upper_o      <= reset_upper;
      key_color_o  <= reset_key_color;
    end else if (wr_en) begin
      case (addr)
        reg_ctrl: begin
          key_enable_o <= pwdata_i[0];
          channel_o    <= channel_sel_e'(pwdata_i[2:1]);
        end
        reg_lower:     lower_o     <= pwdata_i[7:0];
        reg_upper:     upper_o     <= pwdata_i[7:0];
        reg_key_color: key_color_o <= pwdata_i[15:0];
        default: ;
      endcase
    end
  end

  // status: sticky overflow with write-1-to-clear, plus frame count
  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      overflow_q    <= 1'b0;
      frame_count_q <= '0;
    end else begin
      // a new drop in the same cycle as the clear keeps the flag set
      if (overflow_i) begin
        overflow_q <= 1'b1;
      end else if (wr_en && addr == reg_status && pwdata_i[0]) begin
        overflow_q <= 1'b0;
      end
      if (frame_done_i) begin
        frame_count_q <= frame_count_q + 1'b1;
      end
    end
  end

endmodule

//--- rtl/pixel_reconstruct.sv
module pixel_reconstruct #(
  parameter int frame_width  = 1280,
  parameter int frame_height = 720
) (
  input  logic             clk_camera,
  input  logic             recent_reset,
  input  logic             cam_pclk_i,
  input  logic             cam_hsync_i,
  input  logic             cam_vsync_i,
  input  cam_pkg::byte_t   cam_data_i,
  output logic             pixel_valid_o,
  output cam_pkg::pixel_t  pixel_o,
  output logic             pixel_last_o
);
  import cam_pkg::*;

  // counters get one spare count so they can step past the last line
  localparam int hcount_w = $clog2(frame_width + 1);
  localparam int vcount_w = $clog2(frame_height + 1);

  // ============================================================
  // input synchronizers and edge detection
  // ============================================================

  logic  pclk_meta, pclk_sync, pclk_prev;
  logic  hsync_meta, hsync_sync, hsync_prev;
  logic  vsync_meta, vsync_sync, vsync_prev;
  byte_t data_meta, data_sync;

  logic pclk_rise;
  logic hsync_fall;
  logic vsync_rise;

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      pclk_meta  <= 1'b0;
      pclk_sync  <= 1'b0;
      pclk_prev  <= 1'b0;
      hsync_meta <= 1'b0;
      hsync_sync <= 1'b0;
      hsync_prev <= 1'b0;
      vsync_meta <= 1'b0;
      vsync_sync <= 1'b0;
      vsync_prev <= 1'b0;
    end else begin
      pclk_meta  <= cam_pclk_i;
      pclk_sync  <= pclk_meta;
      pclk_prev  <= pclk_sync;
      hsync_meta <= cam_hsync_i;
      hsync_sync <= hsync_meta;
      hsync_prev <= hsync_sync;
      vsync_meta <= cam_vsync_i;
      vsync_sync <= vsync_meta;
      vsync_prev <= vsync_sync;
    end
  end

  // data bus follows the same two-flop path
  always_ff @(posedge clk_camera) begin
    data_meta <= cam_data_i;
    data_sync <= data_meta;
  end

  assign pclk_rise  = pclk_sync & ~pclk_prev;
  assign hsync_fall = ~hsync_sync & hsync_prev;
  assign vsync_rise = vsync_sync & ~vsync_prev;

  // ============================================================
  // event register stage
  // ============================================================

  logic  byte_strobe_q;
  logic  line_active_q;
  logic  line_end_q;
  logic  frame_start_q;
  byte_t byte_q;

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      byte_strobe_q <= 1'b0;
      line_active_q <= 1'b0;
      line_end_q    <= 1'b0;
      frame_start_q <= 1'b0;
    end else begin
      // bytes only count while hsync marks an active line
      byte_strobe_q <= pclk_rise & hsync_sync;
      line_active_q <= hsync_sync;
      line_end_q    <= hsync_fall;
      frame_start_q <= vsync_rise;
    end
  end

  always_ff @(posedge clk_camera) begin
    byte_q <= data_sync;
  end

  // ============================================================
  // byte pairing and frame position
  // ============================================================

  logic                phase_q;
  byte_t               high_byte_q;
  logic [hcount_w-1:0] hcount_q;
  logic [vcount_w-1:0] vcount_q;
  logic                at_last;

  assign at_last = (hcount_q == hcount_w'(frame_width - 1)) &&
                   (vcount_q == vcount_w'(frame_height - 1));

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      phase_q       <= 1'b0;
      hcount_q      <= '0;
      vcount_q      <= '0;
      pixel_valid_o <= 1'b0;
      pixel_last_o  <= 1'b0;
    end else begin
      pixel_valid_o <= 1'b0;
      pixel_last_o  <= 1'b0;
      if (!line_active_q) begin
        // pairing always restarts at the high byte of a line
        phase_q <= 1'b0;
      end else if (byte_strobe_q) begin
        phase_q <= ~phase_q;
        if (phase_q) begin
          pixel_valid_o <= 1'b1;
          pixel_last_o  <= at_last;
        end
      end
      if (frame_start_q) begin
        hcount_q <= '0;
        vcount_q <= '0;
      end else if (line_end_q) begin
        hcount_q <= '0;
        vcount_q <= vcount_q + 1'b1;
      end else if (byte_strobe_q && phase_q) begin
        hcount_q <= hcount_q + 1'b1;
      end
    end
  end

  // payload side of the pairing
  always_ff @(posedge clk_camera) begin
    if (byte_strobe_q && !phase_q) begin
      high_byte_q <= byte_q;
    end
    if (byte_strobe_q && phase_q) begin
      pixel_o <= {high_byte_q, byte_q};
    end
  end

endmodule

//--- sources.f
rtl/cam_pkg.sv
rtl/pixel_reconstruct.sv
rtl/chroma_key.sv
rtl/chunk_stacker.sv
rtl/key_config_apb.sv
rtl/camera_capture_top.sv
bench/tb_camera_capture.sv
